// File: design/bridge_pkg.sv
// Shared widths, AHB codes and transfer records; data path fixed at 32 bits, singles only
package bridge_pkg;

   // --------------------------------------
   // Bus widths
   // --------------------------------------
   localparam int ADDR_W   = 32;
   localparam int DATA_W   = 32;
   localparam int MASTER_W = 1;           // HMASTER identifier
   localparam int STRB_W   = DATA_W / 8;  // One strobe per byte lane

   // --------------------------------------
   // AHB encodings
   // --------------------------------------
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
   localparam logic [2:0] HBURST_SINGLE = 3'b000;

   // Address phase as captured from the slave port, held until completion
   typedef struct packed {
      logic [ADDR_W-1:0]   addr;
      logic                write;
      logic [1:0]          size;    // Byte, halfword or word
      logic [3:0]          prot;    // HPROT as received
      logic [MASTER_W-1:0] master;
      logic                lock;
   } bridge_req_t;

   // Completion from one engine
   typedef struct packed {
      logic              done;      // One-cycle strobe
      logic              err;       // Only valid with done
      logic [DATA_W-1:0] rdata;
   } bridge_rsp_t;

endpackage

// File: design/ahb_slave_port.sv
// One transfer in flight; bursts run as singles, sizes above word clamp to word, HSELAPBS wins
`timescale 1ns/10ps

module ahb_slave_port import bridge_pkg::*; (
   input  logic                HCLKM,
   input  logic                HRESETMn,

   input  logic                HSELAHBS,
   input  logic                HSELAPBS,
   input  logic                HREADYS,
   input  logic                HWRITES,
   input  logic                HMASTLOCKS,
   input  logic [1:0]          HTRANSS,
   input  logic [2:0]          HSIZES,
   input  logic [ADDR_W-1:0]   HADDRS,
   input  logic [DATA_W-1:0]   HWDATAS,
   input  logic [3:0]          HPROTS,
   input  logic [MASTER_W-1:0] HMASTERS,
   output logic [DATA_W-1:0]   HRDATAS,
   output logic                HREADYOUTS,
   output logic                HRESPS,

   output bridge_req_t         req,
   output logic [DATA_W-1:0]   wdata,
   output logic                ahb_start,
   output logic                apb_start,
   input  bridge_rsp_t         ahb_rsp,
   input  bridge_rsp_t         apb_rsp
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DATA,
      ST_BUSY,
      ST_ERROR
   } state_t;

   state_t            state;
   logic              sel_apb;     // Target chosen in the address phase
   logic              hresp_q;
   logic [DATA_W-1:0] rdata_q;
   logic              trans_act;
   logic              accept;
   bridge_rsp_t       rsp;

   assign trans_act = (HTRANSS == HTRANS_NONSEQ) || (HTRANSS == 2'b11);  // NONSEQ or SEQ
   assign accept    = HREADYS && trans_act && (HSELAHBS || HSELAPBS);

   // Only the started engine can show done
   assign rsp = ahb_rsp.done ? ahb_rsp : apb_rsp;

   // --------------------------------------
   // Transfer FSM
   // --------------------------------------
   always_ff @(posedge HCLKM or negedge HRESETMn) begin
      if (!HRESETMn) begin
         state     <= ST_IDLE;
         sel_apb   <= 1'b0;
         hresp_q   <= 1'b0;
         ahb_start <= 1'b0;
         apb_start <= 1'b0;
      end else begin
         ahb_start <= 1'b0;
         apb_start <= 1'b0;
         case (state)
            ST_IDLE: begin
               hresp_q <= 1'b0;            // Ends second error cycle
               if (accept) begin
                  sel_apb <= HSELAPBS;
                  state   <= ST_DATA;
               end
            end
            ST_DATA: begin
               ahb_start <= !sel_apb;     // Write data is in wdata now
               apb_start <= sel_apb;
               state     <= ST_BUSY;
            end
            ST_BUSY: begin
               if (rsp.done) begin
                  hresp_q <= rsp.err;
                  state   <= rsp.err ? ST_ERROR : ST_IDLE;
               end
            end
            default: state <= ST_IDLE;    // First error cycle done
         endcase
      end
   end

   // Request and data capture
   always_ff @(posedge HCLKM) begin
      if (state == ST_IDLE && accept) begin
         req.addr   <= HADDRS;
         req.write  <= HWRITES;
         req.size   <= (HSIZES > 3'd2) ? 2'b10 : HSIZES[1:0];
         req.prot   <= HPROTS;
         req.master <= HMASTERS;
         req.lock   <= HMASTLOCKS;
      end
      if (state == ST_DATA) begin
         wdata <= HWDATAS;
      end
      if (state == ST_BUSY && rsp.done) begin
         rdata_q <= rsp.rdata;
      end
   end

   assign HREADYOUTS = (state == ST_IDLE);
   assign HRESPS     = hresp_q;
   assign HRDATAS    = rdata_q;

endmodule

// File: design/ahb_master_engine.sv
// Issues one single AHB-Lite transfer per start; req and wdata must stay stable until done
`timescale 1ns/10ps

module ahb_master_engine import bridge_pkg::*; (
   input  logic                HCLKM,
   input  logic                HRESETMn,

   input  logic                start,
   input  bridge_req_t         req,
   input  logic [DATA_W-1:0]   wdata,
   output bridge_rsp_t         rsp,

   output logic [ADDR_W-1:0]   HADDRM,
   output logic [1:0]          HTRANSM,
   output logic [2:0]          HBURSTM,
   output logic [2:0]          HSIZEM,
   output logic [3:0]          HPROTM,
   output logic                HWRITEM,
   output logic                HMASTLOCKM,
   output logic [MASTER_W-1:0] HMASTERM,
   output logic [DATA_W-1:0]   HWDATAM,
   input  logic [DATA_W-1:0]   HRDATAM,
   input  logic                HREADYM,
   input  logic                HRESPM,
   output logic                HACTIVEM
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,
      ST_DATA
   } state_t;

   state_t state;

   always_ff @(posedge HCLKM or negedge HRESETMn) begin
      if (!HRESETMn) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (start) state <= ST_ADDR;
            ST_ADDR: if (HREADYM) state <= ST_DATA;
            // First error cycle has HREADYM low, so the wait covers it
            ST_DATA: if (HREADYM) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      rsp.done  = (state == ST_DATA) && HREADYM;
      rsp.err   = rsp.done && HRESPM;
      rsp.rdata = HRDATAM;
   end

   // Address phase straight from the held request
   assign HTRANSM    = (state == ST_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign HADDRM     = req.addr;
   assign HBURSTM    = HBURST_SINGLE;
   assign HSIZEM     = {1'b0, req.size};
   assign HPROTM     = req.prot;
   assign HWRITEM    = req.write;
   assign HMASTERM   = req.master;
   assign HMASTLOCKM = req.lock && (state != ST_IDLE);
   assign HWDATAM    = wdata;

   assign HACTIVEM   = start || (state != ST_IDLE);  // Clock needed from start

endmodule

// File: design/apb_master_engine.sv
// One APB4 setup and access per start; address word-aligned, lanes derived from size and address
`timescale 1ns/10ps

module apb_master_engine import bridge_pkg::*; (
   input  logic                HCLKM,
   input  logic                HRESETMn,

   input  logic                start,
   input  bridge_req_t         req,
   input  logic [DATA_W-1:0]   wdata,
   output bridge_rsp_t         rsp,

   output logic [ADDR_W-1:0]   PADDRM,
   output logic                PSELM,
   output logic                PENABLEM,
   output logic                PWRITEM,
   output logic [2:0]          PPROTM,
   output logic [STRB_W-1:0]   PSTRBM,
   output logic [DATA_W-1:0]   PWDATAM,
   output logic [MASTER_W-1:0] PMASTERM,
   input  logic [DATA_W-1:0]   PRDATAM,
   input  logic                PREADYM,
   input  logic                PSLVERRM,
   output logic                PACTIVEM
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS
   } state_t;

   state_t            state;
   logic [STRB_W-1:0] strb;

   always_ff @(posedge HCLKM or negedge HRESETMn) begin
      if (!HRESETMn) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:   if (start) state <= ST_SETUP;
            ST_SETUP:  state <= ST_ACCESS;
            ST_ACCESS: if (PREADYM) state <= ST_IDLE;  // Wait states extend access
            default:   state <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      rsp.done  = (state == ST_ACCESS) && PREADYM;
      rsp.err   = rsp.done && PSLVERRM;
      rsp.rdata = PRDATAM;
   end

   // --------------------------------------
   // Byte lane strobes
   // --------------------------------------
   always_comb begin
      if (!req.write) begin
         strb = '0;                                  // APB4 reads carry no strobes
      end else if (req.size[1]) begin
         strb = '1;
      end else if (req.size[0]) begin
         strb = req.addr[1] ? 4'b1100 : 4'b0011;
      end else begin
         strb = 4'b0001 << req.addr[1:0];
      end
   end

   assign PSELM    = (state != ST_IDLE);
   assign PENABLEM = (state == ST_ACCESS);
   assign PADDRM   = {req.addr[ADDR_W-1:2], 2'b00};
   assign PWRITEM  = req.write;
   assign PSTRBM   = strb;
   assign PWDATAM  = wdata;
   assign PMASTERM = req.master;

   // Privileged from HPROT[1], instruction from HPROT[0] low
   assign PPROTM   = {~req.prot[0], 1'b0, req.prot[1]};

   assign PACTIVEM = start || (state != ST_IDLE);

endmodule

// File: design/bridge_top.sv
// Single-clock AHB-Lite to AHB-Lite and APB4 bridge; HSELAHBS or HSELAPBS picks the master port
`timescale 1ns/10ps

module bridge_top import bridge_pkg::*; (
   input  logic                HCLKM,
   input  logic                HRESETMn,

   // AHB-Lite slave
   input  logic                HSELAHBS,
   input  logic                HSELAPBS,
   input  logic                HREADYS,
   input  logic                HWRITES,
   input  logic                HMASTLOCKS,
   input  logic [1:0]          HTRANSS,
   input  logic [2:0]          HSIZES,
   input  logic [ADDR_W-1:0]   HADDRS,
   input  logic [DATA_W-1:0]   HWDATAS,
   input  logic [3:0]          HPROTS,
   input  logic [MASTER_W-1:0] HMASTERS,
   output logic [DATA_W-1:0]   HRDATAS,
   output logic                HREADYOUTS,
   output logic                HRESPS,

   // AHB-Lite master
   output logic [ADDR_W-1:0]   HADDRM,
   output logic [1:0]          HTRANSM,
   output logic [2:0]          HBURSTM,
   output logic [2:0]          HSIZEM,
   output logic [3:0]          HPROTM,
   output logic                HWRITEM,
   output logic                HMASTLOCKM,
   output logic [MASTER_W-1:0] HMASTERM,
   output logic [DATA_W-1:0]   HWDATAM,
   input  logic [DATA_W-1:0]   HRDATAM,
   input  logic                HREADYM,
   input  logic                HRESPM,

   // APB4 master
   output logic [ADDR_W-1:0]   PADDRM,
   output logic                PSELM,
   output logic                PENABLEM,
   output logic                PWRITEM,
   output logic [2:0]          PPROTM,
   output logic [STRB_W-1:0]   PSTRBM,
   output logic [DATA_W-1:0]   PWDATAM,
   output logic [MASTER_W-1:0] PMASTERM,
   input  logic [DATA_W-1:0]   PRDATAM,
   input  logic                PREADYM,
   input  logic                PSLVERRM,

   // Clock gating levels
   output logic                HACTIVEM,
   output logic                PACTIVEM
);

   bridge_req_t       req;
   logic [DATA_W-1:0] wdata;
   logic              ahb_start;
   logic              apb_start;
   bridge_rsp_t       ahb_rsp;
   bridge_rsp_t       apb_rsp;

   ahb_slave_port u_slave (
      .HCLKM      (HCLKM),
      .HRESETMn   (HRESETMn),
      .HSELAHBS   (HSELAHBS),
      .HSELAPBS   (HSELAPBS),
      .HREADYS    (HREADYS),
      .HWRITES    (HWRITES),
      .HMASTLOCKS (HMASTLOCKS),
      .HTRANSS    (HTRANSS),
      .HSIZES     (HSIZES),
      .HADDRS     (HADDRS),
      .HWDATAS    (HWDATAS),
      .HPROTS     (HPROTS),
      .HMASTERS   (HMASTERS),
      .HRDATAS    (HRDATAS),
      .HREADYOUTS (HREADYOUTS),
      .HRESPS     (HRESPS),
      .req        (req),
      .wdata      (wdata),
      .ahb_start  (ahb_start),
      .apb_start  (apb_start),
      .ahb_rsp    (ahb_rsp),
      .apb_rsp    (apb_rsp)
   );

   // --------------------------------------
   // Master side engines
   // --------------------------------------
   ahb_master_engine u_ahb (
      .HCLKM      (HCLKM),
      .HRESETMn   (HRESETMn),
      .start      (ahb_start),
      .req        (req),
      .wdata      (wdata),
      .rsp        (ahb_rsp),
      .HADDRM     (HADDRM),
      .HTRANSM    (HTRANSM),
      .HBURSTM    (HBURSTM),
      .HSIZEM     (HSIZEM),
      .HPROTM     (HPROTM),
      .HWRITEM    (HWRITEM),
      .HMASTLOCKM (HMASTLOCKM),
      .HMASTERM   (HMASTERM),
      .HWDATAM    (HWDATAM),
      .HRDATAM    (HRDATAM),
      .HREADYM    (HREADYM),
      .HRESPM     (HRESPM),
      .HACTIVEM   (HACTIVEM)
   );

   apb_master_engine u_apb (
      .HCLKM      (HCLKM),
      .HRESETMn   (HRESETMn),
      .start      (apb_start),
      .req        (req),
      .wdata      (wdata),
      .rsp        (apb_rsp),
      .PADDRM     (PADDRM),
      .PSELM      (PSELM),
      .PENABLEM   (PENABLEM),
      .PWRITEM    (PWRITEM),
      .PPROTM     (PPROTM),
      .PSTRBM     (PSTRBM),
      .PWDATAM    (PWDATAM),
      .PMASTERM   (PMASTERM),
      .PRDATAM    (PRDATAM),
      .PREADYM    (PREADYM),
      .PSLVERRM   (PSLVERRM),
      .PACTIVEM   (PACTIVEM)
   );

endmodule

// File: verif/tb_bridge_tasks.svh
// Included inside tb_bridge after its signals; memories decode address bits 7:2 only
`ifndef TB_BRIDGE_TASKS_SVH
`define TB_BRIDGE_TASKS_SVH

int          checks = 0;
int          errors = 0;
string       test_name = "reset";
logic [31:0] ref_mem [2][64];   // Expected contents per side (0 AHB, 1 APB)

// --------------------------------------
// Helpers
// --------------------------------------
task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
   checks++;
   assert (act === exp) else begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, name, exp, act);
   end
endtask

function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] off);
   case (size)
      2'd0:    return 4'b0001 << off;
      2'd1:    return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
   endcase
endfunction

// APB protection expected for a given HPROT
function automatic logic [2:0] pprot_from_hprot(input logic [3:0] hprot);
   logic [2:0] pprot;
   pprot    = 3'b000;                // Secure access
   pprot[0] = hprot[1];              // Privileged
   pprot[2] = (hprot[0] == 1'b0);    // Opcode fetch means instruction access
   return pprot;
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] strb);
   logic [31:0] res;
   res = old;
   for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
   end
   return res;
endfunction

// Pattern built from side and word index
function automatic void init_memories();
   for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 64; i++) begin
         ref_mem[s][i] = {16'hc0de, 8'(s), 2'b00, 6'(i)};
         dev_mem[s][i] = ref_mem[s][i];
      end
   end
endfunction

task automatic check_reset_state();
   check_val("HREADYOUTS", 32'd1, 32'(HREADYOUTS));
   check_val("HRESPS", 32'd0, 32'(HRESPS));
   check_val("HTRANSM", 32'(HTRANS_IDLE), 32'(HTRANSM));
   check_val("HMASTLOCKM", 32'd0, 32'(HMASTLOCKM));
   check_val("PSELM", 32'd0, 32'(PSELM));
   check_val("PENABLEM", 32'd0, 32'(PENABLEM));
   check_val("HACTIVEM", 32'd0, 32'(HACTIVEM));
   check_val("PACTIVEM", 32'd0, 32'(PACTIVEM));
endtask

// --------------------------------------
// One slave-side transfer and the model
// --------------------------------------
task automatic run_transfer(input logic to_apb, input bridge_req_t rq, input logic [31:0] data,
                            input logic err);
   int         cyc;
   int         err_cycles;
   int         ahb_before;
   int         apb_before;
   int         side;
   logic [5:0] idx;
   side       = to_apb ? 1 : 0;
   idx        = rq.addr[7:2];
   ahb_before = ahb_seen;
   apb_before = apb_seen;
   @(negedge HCLKM);
   cur_req    = rq;
   cur_wdata  = data;
   cur_err    = err;
   HSELAHBS   = !to_apb;
   HSELAPBS   = to_apb;
   HTRANSS    = HTRANS_NONSEQ;
   HADDRS     = rq.addr;
   HWRITES    = rq.write;
   HSIZES     = {1'b0, rq.size};
   HPROTS     = rq.prot;
   HMASTERS   = rq.master;
   HMASTLOCKS = rq.lock;
   @(negedge HCLKM);
   HTRANSS    = HTRANS_IDLE;     // Data phase
   HSELAHBS   = 1'b0;
   HSELAPBS   = 1'b0;
   HWDATAS    = data;
   cyc        = 0;
   err_cycles = 0;
   while (!HREADYOUTS && cyc < TIMEOUT) begin
      if (HRESPS) err_cycles++;  // First error cycle
      @(negedge HCLKM);
      cyc++;
   end
   checks++;
   assert (HREADYOUTS) else begin
      errors++;
      $display("HREADYOUTS never returned high in test %s", test_name);
   end
   check_val("HRESPS", 32'(err), 32'(HRESPS));
   check_val("error cycles", err ? 32'd1 : 32'd0, 32'(err_cycles));
   check_val("AHB route", 32'(ahb_before + (to_apb ? 0 : 1)), 32'(ahb_seen));
   check_val("APB route", 32'(apb_before + (to_apb ? 1 : 0)), 32'(apb_seen));
   if (!err && rq.write) begin
      ref_mem[side][idx] = merge_bytes(ref_mem[side][idx], data, lane_mask(rq.size, rq.addr[1:0]));
   end else if (!err) begin
      check_val("HRDATAS", ref_mem[side][idx], HRDATAS);
   end
endtask

task automatic random_transfer(input logic to_apb, input logic allow_err);
   bridge_req_t rq;
   logic        err;
   rq.size   = 2'($urandom_range(0, 2));
   rq.addr   = $urandom;
   if (rq.size == 2'd1) rq.addr[0] = 1'b0;     // Natural alignment
   if (rq.size == 2'd2) rq.addr[1:0] = 2'b00;
   rq.write  = 1'($urandom_range(0, 1));
   rq.prot   = 4'($urandom);
   rq.master = MASTER_W'($urandom);
   rq.lock   = 1'($urandom);
   err       = allow_err && ($urandom_range(0, 3) == 0);
   run_transfer(to_apb, rq, $urandom, err);
endtask

`endif

// File: verif/tb_bridge.sv
// Random singles from a fixed seed on both ports; responders add 0 to 3 wait states each
`timescale 1ns/10ps

module tb_bridge import bridge_pkg::*; ();

   localparam int SEED    = 32'hdca9;
   localparam int PERIOD  = 4;
   localparam int TIMEOUT = 200;      // Cycles per transfer
   localparam int N_AHB   = 60;
   localparam int N_APB   = 60;
   localparam int N_MIXED = 80;

   logic                HCLKM = 1'b0;
   logic                HRESETMn;
   logic                HSELAHBS, HSELAPBS, HREADYS, HWRITES, HMASTLOCKS;
   logic [1:0]          HTRANSS;
   logic [2:0]          HSIZES;
   logic [ADDR_W-1:0]   HADDRS;
   logic [DATA_W-1:0]   HWDATAS, HRDATAS;
   logic [3:0]          HPROTS;
   logic [MASTER_W-1:0] HMASTERS;
   logic                HREADYOUTS, HRESPS;
   // AHB master side
   logic [ADDR_W-1:0]   HADDRM;
   logic [1:0]          HTRANSM;
   logic [2:0]          HBURSTM, HSIZEM;
   logic [3:0]          HPROTM;
   logic                HWRITEM, HMASTLOCKM, HACTIVEM;
   logic [MASTER_W-1:0] HMASTERM;
   logic [DATA_W-1:0]   HWDATAM;
   logic [DATA_W-1:0]   HRDATAM = '0;
   logic                HREADYM = 1'b1;
   logic                HRESPM = 1'b0;
   // APB master side
   logic [ADDR_W-1:0]   PADDRM;
   logic                PSELM, PENABLEM, PWRITEM, PACTIVEM;
   logic [2:0]          PPROTM;
   logic [STRB_W-1:0]   PSTRBM;
   logic [DATA_W-1:0]   PWDATAM;
   logic [MASTER_W-1:0] PMASTERM;
   logic [DATA_W-1:0]   PRDATAM = '0;
   logic                PREADYM = 1'b0;
   logic                PSLVERRM = 1'b0;

   bridge_req_t cur_req;              // Transfer in flight for the responders
   logic [31:0] cur_wdata;
   logic        cur_err;
   logic [31:0] dev_mem [2][64];
   int          ahb_seen = 0;         // Address phases seen per side
   int          apb_seen = 0;

   `include "tb_bridge_tasks.svh"

   always #(PERIOD / 2) HCLKM = ~HCLKM;

   bridge_top dut_i (.*);

   // --------------------------------------
   // AHB-Lite memory responder
   // --------------------------------------
   logic        ahb_dph = 1'b0;
   int          ahb_wait;
   logic [31:0] a_addr;
   logic [1:0]  a_size;
   logic        a_write;

   always @(negedge HCLKM) begin
      if (!ahb_dph) begin
         HREADYM = 1'b1;
         HRESPM  = 1'b0;
      end else if (ahb_wait > 0) begin
         HREADYM  = 1'b0;
         ahb_wait = ahb_wait - 1;
      end else if (cur_err && !HRESPM) begin
         HREADYM = 1'b0;                // First error cycle
         HRESPM  = 1'b1;
      end else begin
         HREADYM = 1'b1;
         HRDATAM = dev_mem[0][a_addr[7:2]];
         if (a_write && !cur_err) begin
            check_val("HWDATAM", cur_wdata, HWDATAM);
            dev_mem[0][a_addr[7:2]] = merge_bytes(dev_mem[0][a_addr[7:2]], HWDATAM,
                                                  lane_mask(a_size, a_addr[1:0]));
         end
         ahb_dph = 1'b0;
      end
      if (HRESETMn && !ahb_dph && HTRANSM == HTRANS_NONSEQ) begin
         check_val("HADDRM", cur_req.addr, HADDRM);
         check_val("HWRITEM", 32'(cur_req.write), 32'(HWRITEM));
         check_val("HSIZEM", 32'({1'b0, cur_req.size}), 32'(HSIZEM));
         check_val("HPROTM", 32'(cur_req.prot), 32'(HPROTM));
         check_val("HMASTERM", 32'(cur_req.master), 32'(HMASTERM));
         check_val("HMASTLOCKM", 32'(cur_req.lock), 32'(HMASTLOCKM));
         check_val("HBURSTM", 32'(HBURST_SINGLE), 32'(HBURSTM));
         check_val("HACTIVEM", 32'd1, 32'(HACTIVEM));
         a_addr   = HADDRM;
         a_size   = HSIZEM[1:0];
         a_write  = HWRITEM;
         ahb_seen = ahb_seen + 1;
         ahb_wait = $urandom_range(0, 3);
         ahb_dph  = 1'b1;
      end
   end

   // --------------------------------------
   // APB4 memory responder
   // --------------------------------------
   int apb_wait;

   always @(negedge HCLKM) begin
      if (PSELM) check_val("PACTIVEM", 32'd1, 32'(PACTIVEM));
      if (PSELM && !PENABLEM) begin     // Setup
         check_val("PADDRM", cur_req.addr & 32'hffff_fffc, PADDRM);
         check_val("PWRITEM", 32'(cur_req.write), 32'(PWRITEM));
         check_val("PSTRBM", cur_req.write ? 32'(lane_mask(cur_req.size, cur_req.addr[1:0]))
                                           : 32'd0, 32'(PSTRBM));
         check_val("PPROTM", 32'(pprot_from_hprot(cur_req.prot)), 32'(PPROTM));
         check_val("PMASTERM", 32'(cur_req.master), 32'(PMASTERM));
         apb_seen = apb_seen + 1;
         apb_wait = $urandom_range(0, 3);
         PREADYM  = 1'b0;
      end else if (PSELM && apb_wait > 0) begin
         PREADYM  = 1'b0;
         apb_wait = apb_wait - 1;
      end else if (PSELM) begin
         PREADYM  = 1'b1;
         PSLVERRM = cur_err;
         PRDATAM  = dev_mem[1][PADDRM[7:2]];
         if (PWRITEM && !cur_err) begin
            check_val("PWDATAM", cur_wdata, PWDATAM);
            dev_mem[1][PADDRM[7:2]] = merge_bytes(dev_mem[1][PADDRM[7:2]], PWDATAM, PSTRBM);
         end
      end else begin
         PREADYM  = 1'b0;
         PSLVERRM = 1'b0;
      end
   end

   // --------------------------------------
   // Test sequence
   // --------------------------------------
   initial begin
      HRESETMn   = 1'b0;
      HSELAHBS   = 1'b0;
      HSELAPBS   = 1'b0;
      HREADYS    = 1'b1;
      HWRITES    = 1'b0;
      HMASTLOCKS = 1'b0;
      HTRANSS    = HTRANS_IDLE;
      HSIZES     = 3'd0;
      HADDRS     = '0;
      HWDATAS    = '0;
      HPROTS     = 4'd0;
      HMASTERS   = '0;
      cur_req    = '0;
      cur_wdata  = '0;
      cur_err    = 1'b0;
      void'($urandom(SEED));
      init_memories();
      repeat (4) @(posedge HCLKM);
      @(negedge HCLKM);
      HRESETMn = 1'b1;
      @(negedge HCLKM);
      check_reset_state();
      test_name = "ahb";
      for (int i = 0; i < N_AHB; i++) random_transfer(1'b0, 1'b0);
      test_name = "apb";
      for (int i = 0; i < N_APB; i++) random_transfer(1'b1, 1'b0);
      test_name = "mixed";          // Both ports with random errors
      for (int i = 0; i < N_MIXED; i++) random_transfer(1'($urandom), 1'b1);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+verif
design/bridge_pkg.sv
design/ahb_slave_port.sv
design/ahb_master_engine.sv
design/apb_master_engine.sv
design/bridge_top.sv
verif/tb_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bridge
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= all tests passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv verif/*.sv verif/*.svh) $(FLIST)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

# Shows the output and fails unless the pass line is present
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
